// ==== pixel_pkg.sv ====
package pixel_pkg;

  // Frame buffers in the rotation
  localparam int NUM_BANKS = 3;

  // Bank index, only 0..2 are legal
  typedef logic [1:0] buf_idx_t;

  // Native pixel format of the producer
  typedef struct packed {
    logic [3:0] r;
    logic [3:0] g;
    logic [3:0] b;
  } rgb444_t;

  // Scanout pixel format
  typedef struct packed {
    logic [7:0] r;
    logic [7:0] g;
    logic [7:0] b;
  } rgb888_t;

  // Flicker blend selection
  typedef enum logic [1:0] {
    BLEND_OFF   = 2'd0,
    BLEND_TWO   = 2'd1,
    BLEND_THREE = 2'd2
  } blend_mode_e;

  // One pixel write from the producer, always accepted
  typedef struct packed {
    logic        valid;
    logic [14:0] addr;
    rgb444_t     data;
  } pixel_wr_t;

endpackage

// ==== video_timing_pkg.sv ====
package video_timing_pkg;

  // Pixel clock is clk_sys_36_864 divided by this
  localparam int PIX_DIV = 6;

  // Last x of a line and last y of a frame
  localparam int H_TOTAL_LAST = 400;
  localparam int V_TOTAL_LAST = 257;

  // Active window, hblank drops after H_ACTIVE_START and rises after H_ACTIVE_END
  localparam int H_ACTIVE_START = 31;
  localparam int H_ACTIVE_END   = 255;
  localparam int V_ACTIVE_START = 66;
  localparam int V_ACTIVE_LINES = 144;

  // Horizontal sync window
  localparam int HS_START = 320;
  localparam int HS_LEN   = 32;

  // Vsync edges happen at HS_START of these lines
  localparam int VS_START_LINE = 1;
  localparam int VS_END_LINE   = 4;

  typedef struct packed {
    logic hsync;
    logic vsync;
    logic hblank;
    logic vblank;
  } sync_t;

endpackage

// ==== buffer_rotation.sv ====
module buffer_rotation #(
  parameter int FRAME_PIXELS = 32256
) (
  input  logic                              clk_sys_36_864,
  input  logic                              rst,
  input  pixel_pkg::pixel_wr_t              pix_wr,
  input  logic                              buffering,
  input  logic                              frame_end,
  output logic [pixel_pkg::NUM_BANKS-1:0]   bank_we,
  output pixel_pkg::buf_idx_t               read_idx,
  output pixel_pkg::buf_idx_t               last_idx
);

  pixel_pkg::buf_idx_t wr_idx;
  pixel_pkg::buf_idx_t next_idx;
  logic                frame_done;

  // Last pixel of a frame written
  assign frame_done = pix_wr.valid && (pix_wr.addr == 15'(FRAME_PIXELS - 1));

  // One-hot write enable towards the banks
  always_comb begin
    for (int i = 0; i < pixel_pkg::NUM_BANKS; i++) begin
      bank_we[i] = pix_wr.valid && (wr_idx == pixel_pkg::buf_idx_t'(i));
    end
  end

  // Producer side, advances per completed frame
  always_ff @(posedge clk_sys_36_864) begin
    if (rst) begin
      wr_idx   <= '0;
      next_idx <= '0;
    end else if (!buffering) begin
      wr_idx   <= '0;
      next_idx <= '0;
    end else if (frame_done) begin
      next_idx <= wr_idx;
      if (wr_idx == pixel_pkg::buf_idx_t'(pixel_pkg::NUM_BANKS - 1)) begin
        wr_idx <= '0;
      end else begin
        wr_idx <= wr_idx + 1'b1;
      end
    end
  end

  // Scanout side, only moves at the frame boundary
  always_ff @(posedge clk_sys_36_864) begin
    if (rst) begin
      read_idx <= '0;
      last_idx <= '0;
    end else if (frame_end) begin
      read_idx <= next_idx;
      last_idx <= read_idx;
    end
  end

endmodule

// ==== frame_bank.sv ====
module frame_bank #(
  parameter int FRAME_PIXELS = 32256
) (
  input  logic                              clk_sys_36_864,
  input  logic                              we,
  input  logic [$clog2(FRAME_PIXELS)-1:0]   wr_addr,
  input  pixel_pkg::rgb444_t                wr_data,
  input  logic [$clog2(FRAME_PIXELS)-1:0]   rd_addr,
  output pixel_pkg::rgb444_t                rd_data
);

  // One full frame, maps to block RAM
  pixel_pkg::rgb444_t mem [FRAME_PIXELS];

  always_ff @(posedge clk_sys_36_864) begin
    if (we) begin
      mem[wr_addr] <= wr_data;
    end
  end

  // Read every cycle, data one cycle later
  always_ff @(posedge clk_sys_36_864) begin
    rd_data <= mem[rd_addr];
  end

endmodule

// ==== video_timing_gen.sv ====
module video_timing_gen #(
  parameter int FRAME_PIXELS = 32256
) (
  input  logic                              clk_sys_36_864,
  input  logic                              rst,
  input  logic                              flip,
  output logic                              pix_ce,
  output video_timing_pkg::sync_t           sync,
  output logic [$clog2(FRAME_PIXELS)-1:0]   scan_addr,
  output logic                              frame_end
);

  localparam int ADDR_W = $clog2(FRAME_PIXELS);
  localparam int DIV_W  = $clog2(video_timing_pkg::PIX_DIV);

  logic [DIV_W-1:0] div;
  logic [8:0]       x;
  logic [8:0]       y;
  logic [8:0]       x_nxt;
  logic [8:0]       y_nxt;
  logic             hblank_nxt;
  logic             vblank_nxt;
  logic             hsync_nxt;
  logic             active_nxt;

  // Position shown after the coming pixel step
  always_comb begin
    x_nxt = x + 1'b1;
    y_nxt = y;
    if (x == video_timing_pkg::H_TOTAL_LAST) begin
      x_nxt = '0;
      y_nxt = (y == video_timing_pkg::V_TOTAL_LAST) ? 9'd0 : y + 1'b1;
    end
    hblank_nxt = (x_nxt > video_timing_pkg::H_ACTIVE_END) ||
                 (x_nxt <= video_timing_pkg::H_ACTIVE_START);
    vblank_nxt = (y_nxt < video_timing_pkg::V_ACTIVE_START) ||
                 (y_nxt >= video_timing_pkg::V_ACTIVE_START + video_timing_pkg::V_ACTIVE_LINES);
    hsync_nxt  = (x_nxt >= video_timing_pkg::HS_START) &&
                 (x_nxt < video_timing_pkg::HS_START + video_timing_pkg::HS_LEN);
    active_nxt = !hblank_nxt && !vblank_nxt;
  end

  assign frame_end = pix_ce && (x == video_timing_pkg::H_TOTAL_LAST) &&
                     (y == video_timing_pkg::V_TOTAL_LAST);

  always_ff @(posedge clk_sys_36_864) begin
    if (rst) begin
      div    <= '0;
      pix_ce <= 1'b0;
    end else begin
      pix_ce <= (div == DIV_W'(video_timing_pkg::PIX_DIV - 1));
      div    <= (div == DIV_W'(video_timing_pkg::PIX_DIV - 1)) ? '0 : div + 1'b1;
    end
  end

  always_ff @(posedge clk_sys_36_864) begin
    if (rst) begin
      x         <= '0;
      y         <= '0;
      sync      <= '{hsync: 1'b0, vsync: 1'b0, hblank: 1'b1, vblank: 1'b1};
      scan_addr <= '0;
    end else if (pix_ce) begin
      x           <= x_nxt;
      y           <= y_nxt;
      sync.hsync  <= hsync_nxt;
      sync.hblank <= hblank_nxt;
      sync.vblank <= vblank_nxt;
      if (x_nxt == video_timing_pkg::HS_START) begin
        if (y_nxt == video_timing_pkg::VS_START_LINE) begin
          sync.vsync <= 1'b1;
        end else if (y_nxt == video_timing_pkg::VS_END_LINE) begin
          sync.vsync <= 1'b0;
        end
      end
      // Address runs one pixel ahead to cover the bank read latency
      if (vblank_nxt) begin
        scan_addr <= flip ? ADDR_W'(FRAME_PIXELS - 1) : '0;
      end else if (active_nxt) begin
        scan_addr <= flip ? scan_addr - 1'b1 : scan_addr + 1'b1;
      end
    end
  end

endmodule

// ==== flicker_blend.sv ====
module flicker_blend (
  input  logic                   clk_sys_36_864,
  input  logic                   rst,
  input  logic                   pix_ce,
  input  pixel_pkg::blend_mode_e mode,
  input  pixel_pkg::rgb444_t     bank_data [pixel_pkg::NUM_BANKS],
  input  pixel_pkg::buf_idx_t    read_idx,
  input  pixel_pkg::buf_idx_t    last_idx,
  output pixel_pkg::rgb888_t     video
);

  pixel_pkg::rgb444_t rgb_now;
  pixel_pkg::rgb444_t rgb_last;
  pixel_pkg::rgb888_t blended;

  // Average of two frames, sum widened to 8 bits
  function automatic logic [7:0] avg2(input logic [3:0] a, input logic [3:0] b);
    logic [4:0] sum;
    sum = 5'(a) + 5'(b);
    return {sum, sum[4:2]};
  endfunction

  // Average of three frames via multiply by 21845 / 16384
  function automatic logic [7:0] avg3(input logic [3:0] a, input logic [3:0] b,
                                      input logic [3:0] c);
    logic [5:0]  sum;
    logic [7:0]  ext;
    logic [23:0] prod;
    sum  = 6'(a) + 6'(b) + 6'(c);
    ext  = {sum, sum[5:4]};
    prod = 24'(ext) * 24'd21845;
    return prod[21:14];
  endfunction

  always_comb begin
    rgb_now  = bank_data[read_idx];
    rgb_last = bank_data[last_idx];
    case (mode)
      pixel_pkg::BLEND_OFF: begin
        blended.r = {rgb_now.r, rgb_now.r};
        blended.g = {rgb_now.g, rgb_now.g};
        blended.b = {rgb_now.b, rgb_now.b};
      end
      pixel_pkg::BLEND_TWO: begin
        blended.r = avg2(rgb_now.r, rgb_last.r);
        blended.g = avg2(rgb_now.g, rgb_last.g);
        blended.b = avg2(rgb_now.b, rgb_last.b);
      end
      default: begin
        blended.r = avg3(bank_data[0].r, bank_data[1].r, bank_data[2].r);
        blended.g = avg3(bank_data[0].g, bank_data[1].g, bank_data[2].g);
        blended.b = avg3(bank_data[0].b, bank_data[1].b, bank_data[2].b);
      end
    endcase
  end

  always_ff @(posedge clk_sys_36_864) begin
    if (rst) begin
      video <= '0;
    end else if (pix_ce) begin
      video <= blended;
    end
  end

endmodule

// ==== handheld_video_top.sv ====
module handheld_video_top #(
  parameter int FRAME_PIXELS = 32256
) (
  input  logic                    clk_sys_36_864,
  input  logic                    rst,
  input  pixel_pkg::pixel_wr_t    pix_wr,
  input  logic                    use_triple_buffer,
  input  pixel_pkg::blend_mode_e  blend_mode,
  input  logic                    use_flip_horizontal,
  output pixel_pkg::rgb888_t      video,
  output video_timing_pkg::sync_t sync,
  output logic                    pix_ce
);

  localparam int ADDR_W = $clog2(FRAME_PIXELS);

  logic                             buffering;
  logic [pixel_pkg::NUM_BANKS-1:0]  bank_we;
  pixel_pkg::buf_idx_t              read_idx;
  pixel_pkg::buf_idx_t              last_idx;
  logic [ADDR_W-1:0]                scan_addr;
  logic                             frame_end;
  pixel_pkg::rgb444_t               bank_data [pixel_pkg::NUM_BANKS];

  // Three-frame blend needs rotation even without triple buffering
  assign buffering = use_triple_buffer || (blend_mode == pixel_pkg::BLEND_THREE);

  buffer_rotation #(.FRAME_PIXELS(FRAME_PIXELS)) u_rotation (
    .clk_sys_36_864 (clk_sys_36_864),
    .rst            (rst),
    .pix_wr         (pix_wr),
    .buffering      (buffering),
    .frame_end      (frame_end),
    .bank_we        (bank_we),
    .read_idx       (read_idx),
    .last_idx       (last_idx)
  );

  for (genvar i = 0; i < pixel_pkg::NUM_BANKS; i++) begin : g_bank
    frame_bank #(.FRAME_PIXELS(FRAME_PIXELS)) u_bank (
      .clk_sys_36_864 (clk_sys_36_864),
      .we             (bank_we[i]),
      .wr_addr        (pix_wr.addr[ADDR_W-1:0]),
      .wr_data        (pix_wr.data),
      .rd_addr        (scan_addr),
      .rd_data        (bank_data[i])
    );
  end

  video_timing_gen #(.FRAME_PIXELS(FRAME_PIXELS)) u_timing (
    .clk_sys_36_864 (clk_sys_36_864),
    .rst            (rst),
    .flip           (use_flip_horizontal),
    .pix_ce         (pix_ce),
    .sync           (sync),
    .scan_addr      (scan_addr),
    .frame_end      (frame_end)
  );

  flicker_blend u_blend (
    .clk_sys_36_864 (clk_sys_36_864),
    .rst            (rst),
    .pix_ce         (pix_ce),
    .mode           (blend_mode),
    .bank_data      (bank_data),
    .read_idx       (read_idx),
    .last_idx       (last_idx),
    .video          (video)
  );

endmodule

// ==== handheld_video_assertions.sv ====
module handheld_video_assertions (
  input logic                    clk_sys_36_864,
  input logic                    rst,
  input logic                    pix_ce,
  input video_timing_pkg::sync_t sync,
  input pixel_pkg::buf_idx_t     read_idx,
  input pixel_pkg::buf_idx_t     last_idx
);

  // Pixel enable is a one-cycle strobe
  ce_strobe: assert property (@(posedge clk_sys_36_864) disable iff (rst) pix_ce |=> !pix_ce)
    else $error("pix_ce high on two cycles in a row");

  hsync_in_blank: assert property (@(posedge clk_sys_36_864) disable iff (rst)
    sync.hsync |-> sync.hblank)
    else $error("hsync high outside hblank");

  vsync_in_blank: assert property (@(posedge clk_sys_36_864) disable iff (rst)
    sync.vsync |-> sync.vblank)
    else $error("vsync high outside vblank");

  idx_range: assert property (@(posedge clk_sys_36_864) disable iff (rst)
    (read_idx < 2'd3) && (last_idx < 2'd3))
    else $error("Buffer index out of range");

endmodule

bind handheld_video_top handheld_video_assertions u_assertions (
  .clk_sys_36_864 (clk_sys_36_864),
  .rst            (rst),
  .pix_ce         (pix_ce),
  .sync           (sync),
  .read_idx       (read_idx),
  .last_idx       (last_idx)
);

// ==== tb_handheld_video.sv ====
module tb_handheld_video;

  localparam int FRAME_PIXELS = 32256;
  localparam int FRAME_CYCLES = (video_timing_pkg::V_TOTAL_LAST + 1) *
                                (video_timing_pkg::H_TOTAL_LAST + 1) * video_timing_pkg::PIX_DIV;
  // Tests take close to eight frames, two more as margin
  localparam int WATCHDOG_TIME = 10 * FRAME_CYCLES * 10;

  logic                    clk_sys_36_864;
  logic                    rst;
  pixel_pkg::pixel_wr_t    pix_wr;
  logic                    use_triple_buffer;
  pixel_pkg::blend_mode_e  blend_mode;
  logic                    use_flip_horizontal;
  pixel_pkg::rgb888_t      video;
  video_timing_pkg::sync_t sync;
  logic                    pix_ce;
  pixel_pkg::rgb444_t      image [FRAME_PIXELS];
  pixel_pkg::rgb888_t      expected [FRAME_PIXELS];
  int                      seed;

  handheld_video_top uut (
    .clk_sys_36_864      (clk_sys_36_864),
    .rst                 (rst),
    .pix_wr              (pix_wr),
    .use_triple_buffer   (use_triple_buffer),
    .blend_mode          (blend_mode),
    .use_flip_horizontal (use_flip_horizontal),
    .video               (video),
    .sync                (sync),
    .pix_ce              (pix_ce)
  );

  always #5 clk_sys_36_864 = ~clk_sys_36_864;

  initial begin
    #(WATCHDOG_TIME);
    $display("Timeout, the tests did not finish in time");
    $display("Errors found");
    $fatal(1, "Watchdog expired");
  end

  task automatic raise_error(input string reason);
    $display("%s", reason);
    $display("Errors found");
    $fatal(1, "Stopped at first error");
  endtask

  task automatic check_rgb(input pixel_pkg::rgb888_t got, input pixel_pkg::rgb888_t exp,
                           input string what);
    if (got !== exp) begin
      raise_error($sformatf("Mismatch %s: got %h expected %h", what, got, exp));
    end
  endtask

  task automatic check_sync(input video_timing_pkg::sync_t got,
                            input video_timing_pkg::sync_t exp, input string what);
    if (got !== exp) begin
      raise_error($sformatf("Mismatch %s: got %h expected %h", what, got, exp));
    end
  endtask

  // Nibble repeated into a byte
  function automatic pixel_pkg::rgb888_t widen(input pixel_pkg::rgb444_t p);
    return '{r: {p.r, p.r}, g: {p.g, p.g}, b: {p.b, p.b}};
  endfunction

  function automatic logic [7:0] two_channel(input int s);
    return 8'((s << 3) | (s >> 2));
  endfunction

  function automatic logic [7:0] three_channel(input int s);
    int ext;
    ext = (s << 2) | (s >> 4);
    return 8'((ext * 21845) >> 14);
  endfunction

  task automatic set_modes(input logic triple, input pixel_pkg::blend_mode_e mode,
                           input logic flip);
    @(posedge clk_sys_36_864);
    #1;
    use_triple_buffer   = triple;
    blend_mode          = mode;
    use_flip_horizontal = flip;
  endtask

  task automatic write_image();
    for (int i = 0; i < FRAME_PIXELS; i++) begin
      @(posedge clk_sys_36_864);
      #1;
      pix_wr = '{valid: 1'b1, addr: 15'(i), data: image[i]};
    end
    @(posedge clk_sys_36_864);
    #1;
    pix_wr.valid = 1'b0;
  endtask

  task automatic write_constant(input pixel_pkg::rgb444_t colour);
    for (int i = 0; i < FRAME_PIXELS; i++) begin
      image[i] = colour;
    end
    write_image();
  endtask

  task automatic expect_constant(input pixel_pkg::rgb888_t value);
    for (int k = 0; k < FRAME_PIXELS; k++) begin
      expected[k] = value;
    end
  endtask

  task automatic wait_frame_end();
    do begin
      @(negedge clk_sys_36_864);
    end while (!uut.u_timing.frame_end);
  endtask

  // Outputs move in the cycle after pix_ce, so sample on the falling edge
  task automatic next_pixel();
    do begin
      @(negedge clk_sys_36_864);
    end while (!pix_ce);
    @(negedge clk_sys_36_864);
  endtask

  // Walks one whole active frame against the expected image
  task automatic compare_frame();
    int k;
    k = 0;
    while (!sync.vblank) next_pixel();
    while (sync.vblank) next_pixel();
    while (!sync.vblank) begin
      if (!sync.hblank) begin
        if (k >= FRAME_PIXELS) begin
          raise_error("More active pixels than one frame holds");
        end else begin
          check_sync(sync, '0, $sformatf("sync at pixel %0d", k));
          check_rgb(video, expected[k], $sformatf("video at pixel %0d", k));
        end
        k++;
      end
      next_pixel();
    end
    if (k != FRAME_PIXELS) begin
      raise_error($sformatf("Frame showed %0d active pixels, not %0d", k, FRAME_PIXELS));
    end
  endtask

  task automatic reset_state();
    video_timing_pkg::sync_t idle;
    idle = '{hsync: 1'b0, vsync: 1'b0, hblank: 1'b1, vblank: 1'b1};
    @(negedge clk_sys_36_864);
    check_sync(sync, idle, "sync after reset");
    check_rgb(video, '0, "video after reset");
  endtask

  // Follows the raster from reset to the end of the last active line
  task automatic raster_timing();
    video_timing_pkg::sync_t want;
    int                      x;
    int                      y;
    int                      gap;
    logic                    vs;
    x   = 0;
    y   = 0;
    gap = 0;
    vs  = 1'b0;
    while (y < 211) begin
      do begin
        @(negedge clk_sys_36_864);
        gap++;
      end while (!pix_ce);
      if (gap != video_timing_pkg::PIX_DIV) begin
        raise_error($sformatf("Mismatch pix_ce spacing: got %h expected %h", gap,
                              video_timing_pkg::PIX_DIV));
      end
      @(negedge clk_sys_36_864);
      gap = 1;
      // 401 pixels per line
      if (x == 400) begin
        x = 0;
        y++;
      end else begin
        x++;
      end
      // Vsync edges sit at x 320 of lines 1 and 4
      if (x == 320 && y == 1) begin
        vs = 1'b1;
      end else if (x == 320 && y == 4) begin
        vs = 1'b0;
      end
      want.hsync  = (x >= 320) && (x <= 351);
      want.vsync  = vs;
      want.hblank = (x >= 256) || (x <= 31);
      want.vblank = (y < 66) || (y > 209);
      check_sync(sync, want, $sformatf("sync at x %0d y %0d", x, y));
    end
  endtask

  task automatic blend_off_frame();
    set_modes(1'b0, pixel_pkg::BLEND_OFF, 1'b0);
    for (int i = 0; i < FRAME_PIXELS; i++) begin
      image[i] = 12'($random(seed));
      expected[i] = widen(image[i]);
    end
    write_image();
    wait_frame_end();
    compare_frame();
  endtask

  task automatic flipped_frame();
    set_modes(1'b0, pixel_pkg::BLEND_OFF, 1'b1);
    for (int k = 0; k < FRAME_PIXELS; k++) begin
      expected[k] = widen(image[FRAME_PIXELS - 1 - k]);
    end
    wait_frame_end();
    compare_frame();
  endtask

  task automatic triple_buffer_swap(input pixel_pkg::rgb444_t a, input pixel_pkg::rgb444_t b);
    set_modes(1'b1, pixel_pkg::BLEND_OFF, 1'b0);
    write_constant(a);
    wait_frame_end();
    write_constant(b);
    // B stays hidden until the next frame boundary
    expect_constant(widen(a));
    compare_frame();
    wait_frame_end();
    expect_constant(widen(b));
    compare_frame();
  endtask

  task automatic two_frame_blend(input pixel_pkg::rgb444_t p, input pixel_pkg::rgb444_t q);
    pixel_pkg::rgb888_t mixed;
    mixed.r = two_channel(int'(q.r) + int'(p.r));
    mixed.g = two_channel(int'(q.g) + int'(p.g));
    mixed.b = two_channel(int'(q.b) + int'(p.b));
    set_modes(1'b1, pixel_pkg::BLEND_TWO, 1'b0);
    write_constant(p);
    wait_frame_end();
    write_constant(q);
    wait_frame_end();
    expect_constant(mixed);
    compare_frame();
  endtask

  // Rotation comes from the blend mode alone here
  task automatic three_frame_blend(input pixel_pkg::rgb444_t c0, input pixel_pkg::rgb444_t c1,
                                   input pixel_pkg::rgb444_t c2);
    pixel_pkg::rgb888_t mixed;
    mixed.r = three_channel(int'(c0.r) + int'(c1.r) + int'(c2.r));
    mixed.g = three_channel(int'(c0.g) + int'(c1.g) + int'(c2.g));
    mixed.b = three_channel(int'(c0.b) + int'(c1.b) + int'(c2.b));
    set_modes(1'b0, pixel_pkg::BLEND_THREE, 1'b0);
    write_constant(c0);
    write_constant(c1);
    write_constant(c2);
    wait_frame_end();
    expect_constant(mixed);
    compare_frame();
  endtask

  initial begin
    seed                = 67394;
    clk_sys_36_864      = 1'b0;
    rst                 = 1'b1;
    pix_wr              = '0;
    use_triple_buffer   = 1'b0;
    blend_mode          = pixel_pkg::BLEND_OFF;
    use_flip_horizontal = 1'b0;
    repeat (2) @(posedge clk_sys_36_864);
    #1;
    rst = 1'b0;
    reset_state();
    raster_timing();
    blend_off_frame();
    flipped_frame();
    triple_buffer_swap(12'h3c9, 12'ha52);
    two_frame_blend(12'hf10, 12'h27e);
    three_frame_blend(12'h9f3, 12'h4a6, 12'hd0c);
    $display("No errors");
    $finish;
  end

endmodule

// ==== verilog.f ====
pixel_pkg.sv
video_timing_pkg.sv
buffer_rotation.sv
frame_bank.sv
video_timing_gen.sv
flicker_blend.sv
handheld_video_top.sv
handheld_video_assertions.sv
tb_handheld_video.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_handheld_video
FILELIST  ?= verilog.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= No errors
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SRCS := $(shell cat $(FILELIST))
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	grep -q "^$(PASS_MSG)$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
